// ==== hw/sample_settings.svh ====
`ifndef SAMPLE_SETTINGS_SVH
`define SAMPLE_SETTINGS_SVH

// Instruments in one load
`define SAMPLE_INSTRUMENT_COUNT 4

// 74.25 MHz pixel clock at 115200 baud
`define SAMPLE_UART_CLKS_PER_BIT 644

// 16-bit samples per memory word
`define SAMPLE_WORD_SAMPLES 8

// Sample store depth in words
`define SAMPLE_STORE_WORDS 64

`endif

// ==== hw/sample_pkg.sv ====
`default_nettype none

`include "sample_settings.svh"

package sample_pkg;

    localparam int SAMPLE_BITS  = 16;
    localparam int COUNT_BITS   = 24;
    localparam int WORD_BITS    = `SAMPLE_WORD_SAMPLES * SAMPLE_BITS;
    localparam int LANE_W       = $clog2(`SAMPLE_WORD_SAMPLES);
    localparam int STORE_ADDR_W = $clog2(`SAMPLE_STORE_WORDS);
    localparam int INSTR_SEL_W  = $clog2(`SAMPLE_INSTRUMENT_COUNT);

    // One sample from the loader
    typedef struct packed {
        logic                   valid;
        logic [SAMPLE_BITS-1:0] data;
        logic                   last;
    } sample_beat_t;

    // Word offset where the next instrument starts
    typedef struct packed {
        logic                  valid;
        logic [COUNT_BITS-1:0] word;
    } offset_note_t;

    typedef struct packed {
        logic                    valid;
        logic [STORE_ADDR_W-1:0] addr;
        logic [WORD_BITS-1:0]    data;
    } store_write_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    typedef enum logic [1:0] {
        LOAD_SIZE,
        LOAD_DATA,
        LOAD_DONE
    } loader_phase_e;

endpackage

`default_nettype wire

// ==== hw/uart_receive.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_receive #(
    parameter int CLKS_PER_BIT = 644
) (
    input  wire        clk_pixel,
    input  wire        rst_pixel,
    input  wire        din,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    import sample_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CLK = CNT_W'((CLKS_PER_BIT - 1) / 2);

    uart_state_e      state;
    logic [1:0]       din_sync;
    logic [CNT_W-1:0] clk_count;
    logic [2:0]       bit_idx;

    // Two-flop synchroniser on the async line
    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            din_sync <= 2'b11;
        end else begin
            din_sync <= {din_sync[0], din};
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            state      <= UART_IDLE;
            clk_count  <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                UART_IDLE: begin
                    clk_count <= '0;
                    bit_idx   <= '0;
                    if (!din_sync[1]) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    // Recheck at mid start bit to reject glitches
                    if (clk_count == HALF_CLK) begin
                        clk_count <= '0;
                        state     <= din_sync[1] ? UART_IDLE : UART_DATA;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                UART_DATA: begin
                    if (clk_count == LAST_CLK) begin
                        clk_count <= '0;
                        byte_data <= {din_sync[1], byte_data[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: begin
                    // Byte goes out mid stop bit, framing not checked
                    if (clk_count == LAST_CLK) begin
                        clk_count  <= '0;
                        byte_valid <= 1'b1;
                        state      <= UART_IDLE;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
            endcase
        end
    end

    a_single_strobe: assert property (
        @(posedge clk_pixel) disable iff (rst_pixel)
        byte_valid |=> !byte_valid
    );

endmodule

`default_nettype wire

// ==== hw/sample_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sample_settings.svh"

module sample_loader (
    input  wire                     clk_pixel,
    input  wire                     rst_pixel,
    input  wire                     byte_valid,
    input  wire  [7:0]              byte_data,
    output sample_pkg::sample_beat_t beat,
    output sample_pkg::offset_note_t note
);

    import sample_pkg::*;

    localparam logic [INSTR_SEL_W-1:0] LAST_INSTR =
        INSTR_SEL_W'(`SAMPLE_INSTRUMENT_COUNT - 1);

    loader_phase_e          phase;
    logic [1:0]             size_byte;
    logic [COUNT_BITS-1:0]  sample_size;
    logic                   high_byte;
    logic [7:0]             low_byte;
    logic [COUNT_BITS-1:0]  sample_count;
    logic [COUNT_BITS-1:0]  total_count;
    logic [INSTR_SEL_W-1:0] instr_count;

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            phase        <= LOAD_SIZE;
            size_byte    <= '0;
            high_byte    <= 1'b0;
            sample_count <= '0;
            total_count  <= '0;
            instr_count  <= '0;
            beat.valid   <= 1'b0;
            beat.last    <= 1'b0;
            note.valid   <= 1'b0;
        end else begin
            beat.valid <= 1'b0;
            beat.last  <= 1'b0;
            note.valid <= 1'b0;
            if (byte_valid) begin
                case (phase)
                    LOAD_SIZE: begin
                        // Count arrives LSB first
                        sample_size  <= {byte_data, sample_size[COUNT_BITS-1:8]};
                        high_byte    <= 1'b0;
                        sample_count <= '0;
                        if (size_byte == 2'd2) begin
                            size_byte <= '0;
                            phase     <= LOAD_DATA;
                        end else begin
                            size_byte <= size_byte + 2'd1;
                        end
                    end
                    LOAD_DATA: begin
                        high_byte <= ~high_byte;
                        if (!high_byte) begin
                            low_byte <= byte_data;
                        end else begin
                            beat.valid   <= 1'b1;
                            beat.data    <= {byte_data, low_byte};
                            sample_count <= sample_count + 1'b1;
                            total_count  <= total_count + 1'b1;
                            if (sample_count == sample_size - 1'b1) begin
                                // Next instrument starts in the word holding this total
                                note.valid <= 1'b1;
                                note.word  <= (total_count + 1'b1) >> LANE_W;
                                if (instr_count == LAST_INSTR) begin
                                    beat.last <= 1'b1;
                                    phase     <= LOAD_DONE;
                                end else begin
                                    instr_count <= instr_count + 1'b1;
                                    phase       <= LOAD_SIZE;
                                end
                            end
                        end
                    end
                    default: begin
                        // Bytes after the final instrument are dropped
                        phase <= LOAD_DONE;
                    end
                endcase
            end
        end
    end

    // The final sample always closes an instrument
    a_last_with_note: assert property (
        @(posedge clk_pixel) disable iff (rst_pixel)
        beat.last |-> beat.valid && note.valid
    );

endmodule

`default_nettype wire

// ==== hw/sample_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sample_settings.svh"

module sample_packer (
    input  wire                      clk_pixel,
    input  wire                      rst_pixel,
    input  wire  sample_pkg::sample_beat_t beat,
    output sample_pkg::store_write_t wr,
    output logic                     load_done
);

    import sample_pkg::*;

    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`SAMPLE_WORD_SAMPLES - 1);

    logic [LANE_W-1:0]     lane;
    logic [STORE_ADDR_W:0] word_count;
    logic [WORD_BITS-1:0]  acc;
    logic [WORD_BITS-1:0]  acc_next;
    logic                  word_done;
    logic                  flush_pending;

    // Sample 0 sits in the lowest lane
    always_comb begin
        acc_next  = acc | (WORD_BITS'(beat.data) << (lane * SAMPLE_BITS));
        word_done = beat.valid && (lane == LAST_LANE || beat.last);
    end

    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            lane          <= '0;
            word_count    <= '0;
            acc           <= '0;
            wr.valid      <= 1'b0;
            flush_pending <= 1'b0;
            load_done     <= 1'b0;
        end else begin
            wr.valid      <= 1'b0;
            flush_pending <= beat.valid && beat.last;
            if (flush_pending) begin
                load_done <= 1'b1;
            end
            if (beat.valid) begin
                lane <= lane + 1'b1;
                if (word_done) begin
                    // Cleared lanes pad a partial final word with zeros
                    wr.valid   <= 1'b1;
                    wr.addr    <= word_count[STORE_ADDR_W-1:0];
                    wr.data    <= acc_next;
                    acc        <= '0;
                    word_count <= word_count + 1'b1;
                end else begin
                    acc <= acc_next;
                end
            end
        end
    end

    a_store_room: assert property (
        @(posedge clk_pixel) disable iff (rst_pixel)
        beat.valid |-> word_count < `SAMPLE_STORE_WORDS
    );

    a_quiet_after_done: assert property (
        @(posedge clk_pixel) disable iff (rst_pixel)
        load_done |-> !beat.valid
    );

endmodule

`default_nettype wire

// ==== hw/sample_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sample_settings.svh"

module sample_store (
    input  wire                                    clk_pixel,
    input  wire                                    rst_pixel,
    input  wire  sample_pkg::store_write_t         wr,
    input  wire  sample_pkg::offset_note_t         note,
    input  wire  [sample_pkg::STORE_ADDR_W-1:0]    word_addr,
    input  wire  [sample_pkg::INSTR_SEL_W-1:0]     instr_sel,
    output logic [sample_pkg::WORD_BITS-1:0]       word_data,
    output logic [sample_pkg::COUNT_BITS-1:0]      instr_end
);

    import sample_pkg::*;

    logic [WORD_BITS-1:0]  mem [`SAMPLE_STORE_WORDS];
    logic [COUNT_BITS-1:0] offsets [`SAMPLE_INSTRUMENT_COUNT];
    logic [INSTR_SEL_W:0]  note_idx;

    always_ff @(posedge clk_pixel) begin
        if (wr.valid) begin
            mem[wr.addr] <= wr.data;
        end
        word_data <= mem[word_addr];
    end

    // Entries fill in arrival order
    always_ff @(posedge clk_pixel) begin
        if (rst_pixel) begin
            note_idx <= '0;
            for (int i = 0; i < `SAMPLE_INSTRUMENT_COUNT; i++) begin
                offsets[i] <= '0;
            end
        end else if (note.valid) begin
            offsets[note_idx[INSTR_SEL_W-1:0]] <= note.word;
            note_idx <= note_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        instr_end <= offsets[instr_sel];
    end

    a_table_room: assert property (
        @(posedge clk_pixel) disable iff (rst_pixel)
        note.valid |-> note_idx < `SAMPLE_INSTRUMENT_COUNT
    );

endmodule

`default_nettype wire

// ==== hw/sample_bank_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sample_settings.svh"

module sample_bank_top (
    input  wire                                 clk_pixel,
    input  wire                                 rst_pixel,
    input  wire                                 uart_din,
    input  wire  [sample_pkg::STORE_ADDR_W-1:0] word_addr,
    input  wire  [sample_pkg::INSTR_SEL_W-1:0]  instr_sel,
    output logic [sample_pkg::WORD_BITS-1:0]    word_data,
    output logic [sample_pkg::COUNT_BITS-1:0]   instr_end,
    output logic                                load_done
);

    import sample_pkg::*;

    logic         byte_valid;
    logic [7:0]   byte_data;
    sample_beat_t beat;
    offset_note_t note;
    store_write_t wr;

    uart_receive #(
        .CLKS_PER_BIT(`SAMPLE_UART_CLKS_PER_BIT)
    ) u_uart_receive (
        .clk_pixel (clk_pixel),
        .rst_pixel (rst_pixel),
        .din       (uart_din),
        .byte_valid(byte_valid),
        .byte_data (byte_data)
    );

    sample_loader u_sample_loader (
        .clk_pixel (clk_pixel),
        .rst_pixel (rst_pixel),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .beat      (beat),
        .note      (note)
    );

    sample_packer u_sample_packer (
        .clk_pixel(clk_pixel),
        .rst_pixel(rst_pixel),
        .beat     (beat),
        .wr       (wr),
        .load_done(load_done)
    );

    sample_store u_sample_store (
        .clk_pixel(clk_pixel),
        .rst_pixel(rst_pixel),
        .wr       (wr),
        .note     (note),
        .word_addr(word_addr),
        .instr_sel(instr_sel),
        .word_data(word_data),
        .instr_end(instr_end)
    );

endmodule

`default_nettype wire

// ==== test/tb_sample_bank_tasks.svh ====
// Included in the body of tb_sample_bank, after the sample_pkg import

// Holds the line for one bit time, entered on a falling edge
task automatic hold_line(input logic level);
    uart_din = level;
    repeat (`SAMPLE_UART_CLKS_PER_BIT) @(negedge clk_pixel);
endtask

// 8N1 frame, data LSB first
task automatic send_byte(input logic [7:0] value);
    hold_line(1'b0);
    for (int b = 0; b < 8; b++) begin
        hold_line(value[b]);
    end
    hold_line(1'b1);
endtask

task automatic check_word(
    input int                   idx,
    input logic [WORD_BITS-1:0] got,
    input logic [WORD_BITS-1:0] expected
);
    if (got !== expected) begin
        word_errors++;
        $display("FAIL %0t: word %0d read %h, expected %h", $time, idx, got, expected);
    end
endtask

task automatic check_offset(
    input int                    idx,
    input logic [COUNT_BITS-1:0] got,
    input logic [COUNT_BITS-1:0] expected
);
    if (got !== expected) begin
        offset_errors++;
        $display("FAIL %0t: offset entry %0d read %0d, expected %0d",
                 $time, idx, got, expected);
    end
endtask

task automatic read_word(input int n, output logic [WORD_BITS-1:0] data);
    @(negedge clk_pixel);
    word_addr = STORE_ADDR_W'(n);
    @(negedge clk_pixel);
    data = word_data;
endtask

// ==== test/tb_sample_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "sample_settings.svh"

module tb_sample_bank;

    import sample_pkg::*;

    localparam int CLK_HALF_NS = 20;
    localparam int CLK_PERIOD_NS = 2 * CLK_HALF_NS;
    localparam int MAX_COUNT = 20;

    logic                    clk_pixel;
    logic                    rst_pixel;
    logic                    uart_din;
    logic [STORE_ADDR_W-1:0] word_addr;
    logic [INSTR_SEL_W-1:0]  instr_sel;
    logic [WORD_BITS-1:0]    word_data;
    logic [COUNT_BITS-1:0]   instr_end;
    logic                    load_done;

    integer      seed;
    bit          stim_ready;
    int          word_errors;
    int          offset_errors;
    int          other_errors;
    int          load_bytes;
    logic [7:0]  tx_bytes[$];
    logic [15:0] model_samples[$];
    int          cum_total[`SAMPLE_INSTRUMENT_COUNT];

    sample_bank_top dut (
        .clk_pixel(clk_pixel),
        .rst_pixel(rst_pixel),
        .uart_din (uart_din),
        .word_addr(word_addr),
        .instr_sel(instr_sel),
        .word_data(word_data),
        .instr_end(instr_end),
        .load_done(load_done)
    );

    `include "tb_sample_bank_tasks.svh"

    initial begin
        clk_pixel = 1'b0;
        forever #(CLK_HALF_NS) clk_pixel = ~clk_pixel;
    end

    // Random instrument set plus one extra instrument after the load
    task automatic build_stimulus();
        logic [23:0] count;
        logic [15:0] smp;
        int          total;
        total = 0;
        for (int i = 0; i < `SAMPLE_INSTRUMENT_COUNT; i++) begin
            count = 24'(1 + int'($unsigned($random(seed)) % MAX_COUNT));
            tx_bytes.push_back(count[7:0]);
            tx_bytes.push_back(count[15:8]);
            tx_bytes.push_back(count[23:16]);
            for (int s = 0; s < int'(count); s++) begin
                smp = 16'($random(seed));
                model_samples.push_back(smp);
                tx_bytes.push_back(smp[7:0]);
                tx_bytes.push_back(smp[15:8]);
            end
            total += int'(count);
            cum_total[i] = total;
        end
        load_bytes = tx_bytes.size();
        // Well formed, so a loader that kept parsing would rewrite the table
        count = 24'(1 + int'($unsigned($random(seed)) % MAX_COUNT));
        tx_bytes.push_back(count[7:0]);
        tx_bytes.push_back(count[15:8]);
        tx_bytes.push_back(count[23:16]);
        for (int s = 0; s < int'(count); s++) begin
            tx_bytes.push_back(8'($random(seed)));
            tx_bytes.push_back(8'($random(seed)));
        end
    endtask

    // Lanes past the final sample stay zero
    function automatic logic [WORD_BITS-1:0] expected_word(input int n);
        logic [WORD_BITS-1:0] w;
        int                   idx;
        w = '0;
        for (int k = 0; k < `SAMPLE_WORD_SAMPLES; k++) begin
            idx = n * `SAMPLE_WORD_SAMPLES + k;
            if (idx < model_samples.size()) begin
                w[k*SAMPLE_BITS +: SAMPLE_BITS] = model_samples[idx];
            end
        end
        return w;
    endfunction

    task automatic read_offset(input int i, output logic [COUNT_BITS-1:0] data);
        @(negedge clk_pixel);
        instr_sel = INSTR_SEL_W'(i);
        @(negedge clk_pixel);
        data = instr_end;
    endtask

    task automatic check_contents();
        logic [WORD_BITS-1:0]  got_word;
        logic [COUNT_BITS-1:0] got_off;
        int                    n_words;
        n_words = (model_samples.size() + `SAMPLE_WORD_SAMPLES - 1) / `SAMPLE_WORD_SAMPLES;
        for (int n = 0; n < n_words; n++) begin
            read_word(n, got_word);
            check_word(n, got_word, expected_word(n));
        end
        for (int i = 0; i < `SAMPLE_INSTRUMENT_COUNT; i++) begin
            read_offset(i, got_off);
            check_offset(i, got_off, COUNT_BITS'(cum_total[i] / `SAMPLE_WORD_SAMPLES));
        end
    endtask

    initial begin
        rst_pixel = 1'b1;
        uart_din = 1'b1;
        word_addr = '0;
        instr_sel = '0;
        word_errors = 0;
        offset_errors = 0;
        other_errors = 0;
        seed = 32'hcc7a_5913;
        build_stimulus();
        stim_ready = 1'b1;
        repeat (10) @(negedge clk_pixel);
        rst_pixel = 1'b0;
        repeat (4) @(negedge clk_pixel);

        for (int i = 0; i < load_bytes - 1; i++) begin
            send_byte(tx_bytes[i]);
        end
        if (load_done !== 1'b0) begin
            other_errors++;
            $display("load_done went high before the final byte was sent");
        end
        send_byte(tx_bytes[load_bytes-1]);
        wait (load_done === 1'b1);
        check_contents();

        // Bytes after the load must change nothing
        for (int i = load_bytes; i < tx_bytes.size(); i++) begin
            send_byte(tx_bytes[i]);
        end
        if (load_done !== 1'b1) begin
            other_errors++;
            $display("load_done dropped after the extra bytes were sent");
        end
        check_contents();

        $display("errors: word %0d, offset %0d, other %0d",
                 word_errors, offset_errors, other_errors);
        if (word_errors + offset_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Twice the time needed to send every byte
    initial begin
        longint limit_ns;
        wait (stim_ready);
        limit_ns = longint'(tx_bytes.size()) * 10 * `SAMPLE_UART_CLKS_PER_BIT
                   * CLK_PERIOD_NS * 2;
        #(limit_ns);
        $display("Watchdog expired because the load never finished in time");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
+incdir+test
hw/sample_pkg.sv
hw/uart_receive.sv
hw/sample_loader.sv
hw/sample_packer.sv
hw/sample_store.sv
hw/sample_bank_top.sv
test/tb_sample_bank.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_sample_bank
RTL_TOP    = sample_bank_top
FILELIST   = filelist.f
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation reported failure" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
